//--- project.f
rtl/tetris_pkg.sv
rtl/piece_control.sv
rtl/pixel_render.sv
rtl/pixel_fifo.sv
rtl/vga_scan_out.sv
rtl/tetris_display_top.sv
testbench/tb_tetris_display_properties.sv
testbench/tb_tetris_display.sv

//--- Bender.yml
package:
  name: tetris_display

sources:
  - files:
      - rtl/tetris_pkg.sv
      - rtl/piece_control.sv
      - rtl/pixel_render.sv
      - rtl/pixel_fifo.sv
      - rtl/vga_scan_out.sv
      - rtl/tetris_display_top.sv
  - target: test
    files:
      - testbench/tb_tetris_display_properties.sv
      - testbench/tb_tetris_display.sv

//--- testbench/tb_tetris_display.sv
/*
 * testbench for the piece display on a small raster
 * frame capture, reference model, directed tests and reporting
 */
`timescale 1ns/1ps
`default_nettype none

module tb_tetris_display;
	import tetris_pkg::*;

	// ======================================================================
	// raster and run length
	// ======================================================================
	localparam int H_ACTIVE = 64;
	localparam int H_FRONT = 4;
	localparam int H_SYNC = 8;
	localparam int H_BACK = 4;
	localparam int V_ACTIVE = 48;
	localparam int V_FRONT = 2;
	localparam int V_SYNC = 2;
	localparam int V_BACK = 2;
	localparam int CELL_SIZE = 2;
	localparam int FIELD_X0 = 8;
	localparam int FIELD_Y0 = 4;
	localparam int FIFO_DEPTH = 8;
	localparam int CLK_PERIOD = 40;
	// two clocks per pixel
	localparam int FRAME_NS = 2 * CLK_PERIOD * (H_ACTIVE + H_FRONT + H_SYNC + H_BACK) *
		(V_ACTIVE + V_FRONT + V_SYNC + V_BACK);
	// reset 2, sync 1, moves 8, shapes 14, clamp 36, random 24
	localparam int TEST_FRAMES = 85;
	localparam int WATCHDOG_FRAMES = TEST_FRAMES + 15;
	localparam keycode_t MOVE_KEYS [4] = '{KEY_LEFT, KEY_RIGHT, KEY_DOWN, KEY_ROTATE};

	logic clk;
	logic rst;
	keycode_t keycode;
	shape_t shape_sel;
	logic vga_hs;
	logic vga_vs;
	logic vga_de;
	logic [3:0] vga_r;
	logic [3:0] vga_g;
	logic [3:0] vga_b;

	// capture state
	rgb_t cap [V_ACTIVE][H_ACTIVE];
	rgb_t frame [V_ACTIVE][H_ACTIVE];
	int cx = 0;
	int cy = 0;
	bit phase = 1'b0;
	logic prev_hs = 1'b1;
	logic prev_vs = 1'b1;
	int de_clks = 0;
	int hs_clks = 0;
	int vs_lines = 0;
	int last_de_clks = 0;
	int last_hs_clks = 0;
	int last_vs_lines = 0;
	int frame_lines = 0;
	int frame_count = 0;

	// model of the piece and bookkeeping
	int m_col;
	int m_row;
	shape_t m_shape;
	shape_t m_sel;
	rot_t m_rot;
	logic [31:0] rng;
	int errors = 0;
	int checks = 0;
	int tests = 0;

	tetris_display_top #(
		.H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
		.V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK),
		.CELL_SIZE(CELL_SIZE), .FIELD_X0(FIELD_X0), .FIELD_Y0(FIELD_Y0),
		.FIFO_DEPTH(FIFO_DEPTH)
	) uut (
		.clk(clk), .rst(rst), .keycode(keycode), .shape_sel(shape_sel),
		.vga_hs(vga_hs), .vga_vs(vga_vs), .vga_de(vga_de),
		.vga_r(vga_r), .vga_g(vga_g), .vga_b(vga_b)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		#(longint'(WATCHDOG_FRAMES) * FRAME_NS);
		$display("timeout: tests still running after %0d frame periods", WATCHDOG_FRAMES);
		$display("TESTBENCH FAILED");
		$finish;
	end

	// ======================================================================
	// frame capture, sampled mid-cycle
	// ======================================================================
	always @(negedge clk) begin
		if (vga_de === 1'b1) begin
			// colour held two clocks, keep the first
			if (!phase && cx < H_ACTIVE && cy < V_ACTIVE)
				cap[cy][cx] = {vga_r, vga_g, vga_b};
			if (!phase)
				cx++;
			phase = !phase;
			de_clks++;
		end else begin
			phase = 1'b0;
		end
		if (vga_hs === 1'b0)
			hs_clks++;
		// end of a line
		if (prev_hs === 1'b1 && vga_hs === 1'b0) begin
			if (cx > 0) begin
				last_de_clks = de_clks;
				cy++;
			end
			cx = 0;
			de_clks = 0;
			if (vga_vs === 1'b0)
				vs_lines++;
		end
		if (prev_hs === 1'b0 && vga_hs === 1'b1) begin
			last_hs_clks = hs_clks;
			hs_clks = 0;
		end
		// end of a frame, blank frames after reset are skipped
		if (prev_vs === 1'b1 && vga_vs === 1'b0) begin
			if (cy > 0) begin
				for (int y = 0; y < V_ACTIVE; y++)
					for (int x = 0; x < H_ACTIVE; x++)
						frame[y][x] = cap[y][x];
				frame_lines = cy;
				frame_count++;
			end
			cy = 0;
			vs_lines = 0;
		end
		if (prev_vs === 1'b0 && vga_vs === 1'b1)
			last_vs_lines = vs_lines;
		prev_hs = vga_hs;
		prev_vs = vga_vs;
	end

	// ======================================================================
	// reference model
	// ======================================================================
	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] v;
		v = s;
		v = v ^ (v << 13);
		v = v ^ (v >> 17);
		v = v ^ (v << 5);
		return v;
	endfunction

	// nibble i is {col, row} of cell i inside the 4x4 box
	function automatic bit model_fits(input shape_t s, input rot_t r, input int col,
		input int row);
		logic [15:0] offs;
		int c;
		int rw;
		offs = piece_cell_offsets(s, r);
		for (int i = 0; i < 4; i++) begin
			c = col + int'(offs[15-4*i -: 2]);
			rw = row + int'(offs[13-4*i -: 2]);
			if (c < 0 || c > 9 || rw < 0 || rw > 19)
				return 1'b0;
		end
		return 1'b1;
	endfunction

	// one frame boundary: move first, then shape select
	task automatic model_step(input keycode_t k);
		int col;
		int row;
		rot_t rot;
		col = m_col;
		row = m_row;
		rot = m_rot;
		case (k)
			KEY_LEFT: col--;
			KEY_RIGHT: col++;
			KEY_DOWN: row++;
			KEY_ROTATE: rot++;
			default: ;
		endcase
		if (model_fits(m_shape, rot, col, row)) begin
			m_col = col;
			m_row = row;
			m_rot = rot;
		end
		if (m_sel != 3'd0 && m_sel != 3'd7 && model_fits(m_sel, m_rot, m_col, m_row))
			m_shape = m_sel;
	endtask

	function automatic rgb_t expected_color(input int x, input int y);
		logic [15:0] offs;
		int gx;
		int gy;
		if (x < FIELD_X0 || x >= FIELD_X0 + 10 * CELL_SIZE ||
			y < FIELD_Y0 || y >= FIELD_Y0 + 20 * CELL_SIZE)
			return 12'h000;
		gx = (x - FIELD_X0) / CELL_SIZE;
		gy = (y - FIELD_Y0) / CELL_SIZE;
		offs = piece_cell_offsets(m_shape, m_rot);
		for (int i = 0; i < 4; i++)
			if (gx == m_col + int'(offs[15-4*i -: 2]) && gy == m_row + int'(offs[13-4*i -: 2]))
				return SHAPE_COLOR[m_shape];
		return 12'h222;
	endfunction

	// ======================================================================
	// checks and helpers
	// ======================================================================
	task automatic check_color(input rgb_t got, input rgb_t exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Fail at %0t: %s, got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_count(input int got, input int exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Fail at %0t: %s, got %0d expected %0d", $time, what, got, exp);
		end
	endtask

	// reports the first wrong pixel of the last captured frame
	task automatic compare_frame(input string name);
		int bx;
		int by;
		bit bad;
		bx = 0;
		by = 0;
		bad = 1'b0;
		for (int y = 0; y < V_ACTIVE; y++)
			for (int x = 0; x < H_ACTIVE; x++)
				if (!bad && frame[y][x] !== expected_color(x, y)) begin
					bad = 1'b1;
					bx = x;
					by = y;
				end
		check_color(frame[by][bx], expected_color(bx, by),
			$sformatf("%s pixel (%0d,%0d)", name, bx, by));
	endtask

	function automatic int count_color(input rgb_t c);
		int n;
		n = 0;
		for (int y = 0; y < V_ACTIVE; y++)
			for (int x = 0; x < H_ACTIVE; x++)
				if (frame[y][x] === c)
					n++;
		return n;
	endfunction

	task automatic piece_bounds(input rgb_t c, output int min_x, output int max_y);
		min_x = H_ACTIVE;
		max_y = -1;
		for (int y = 0; y < V_ACTIVE; y++)
			for (int x = 0; x < H_ACTIVE; x++)
				if (frame[y][x] === c) begin
					if (x < min_x)
						min_x = x;
					if (y > max_y)
						max_y = y;
				end
	endtask

	// returns just after a vga_vs fall, aligned for driving
	task automatic wait_frames(input int n);
		int target;
		target = frame_count + n;
		wait (frame_count >= target);
		@(posedge clk);
		#2;
	endtask

	task automatic press_key(input keycode_t k);
		keycode = k;
		@(posedge clk);
		#2;
		keycode = 8'h00;
		model_step(k);
	endtask

	task automatic test_done(input string name, input int errors_before);
		tests++;
		$display("test %-8s done, %0d new errors", name, errors - errors_before);
	endtask

	// ======================================================================
	// directed tests
	// ======================================================================
	task automatic test_reset();
		int e0;
		e0 = errors;
		check_count(vga_hs, 1, "vga_hs after reset");
		check_count(vga_vs, 1, "vga_vs after reset");
		check_count(vga_de, 0, "vga_de after reset");
		wait_frames(1);
		compare_frame("first frame");
		test_done("reset", e0);
	endtask

	task automatic test_sync();
		int e0;
		e0 = errors;
		wait_frames(1);
		check_count(last_de_clks, 2 * H_ACTIVE, "vga_de clocks per line");
		check_count(last_hs_clks, 2 * H_SYNC, "vga_hs low clocks per line");
		check_count(frame_lines, V_ACTIVE, "active lines per frame");
		check_count(last_vs_lines, V_SYNC, "vga_vs low lines");
		test_done("sync", e0);
	endtask

	task automatic test_moves();
		int e0;
		e0 = errors;
		for (int i = 0; i < 4; i++) begin
			press_key(MOVE_KEYS[i]);
			wait_frames(2);
			compare_frame($sformatf("move key %h", MOVE_KEYS[i]));
		end
		test_done("moves", e0);
	endtask

	task automatic test_shapes();
		int e0;
		e0 = errors;
		// shape 0 only comes from reset, 7 must be ignored
		for (int s = 1; s <= 7; s++) begin
			shape_sel = shape_t'(s);
			m_sel = shape_t'(s);
			model_step(8'h00);
			wait_frames(2);
			compare_frame($sformatf("shape_sel %0d", s));
			check_count(count_color(SHAPE_COLOR[(s == 7) ? 6 : s]), 4 * CELL_SIZE * CELL_SIZE,
				$sformatf("piece pixels for shape_sel %0d", s));
		end
		test_done("shapes", e0);
	endtask

	task automatic test_clamp();
		int e0;
		int min_x;
		int max_y;
		e0 = errors;
		// one press per frame, each consumed before the next
		repeat (10) begin
			press_key(KEY_LEFT);
			wait_frames(1);
		end
		repeat (25) begin
			press_key(KEY_DOWN);
			wait_frames(1);
		end
		wait_frames(1);
		compare_frame("clamped");
		piece_bounds(SHAPE_COLOR[m_shape], min_x, max_y);
		check_count(min_x, FIELD_X0, "piece left edge");
		check_count(max_y, FIELD_Y0 + 20 * CELL_SIZE - 1, "piece bottom edge");
		test_done("clamp", e0);
	endtask

	task automatic test_random();
		int e0;
		keycode_t k;
		e0 = errors;
		for (int i = 0; i < 12; i++) begin
			rng = xorshift(rng);
			k = MOVE_KEYS[rng[1:0]];
			press_key(k);
			wait_frames(2);
			compare_frame($sformatf("random step %0d key %h", i, k));
		end
		test_done("random", e0);
	endtask

	initial begin
		rst = 1'b1;
		keycode = 8'h00;
		shape_sel = 3'd0;
		m_sel = 3'd0;
		m_shape = 3'd0;
		m_col = 3;
		m_row = 0;
		m_rot = 2'd0;
		rng = 32'hb19a;
		repeat (8) @(posedge clk);
		#2;
		rst = 1'b0;
		test_reset();
		test_sync();
		test_moves();
		test_shapes();
		test_clamp();
		test_random();
		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- testbench/tb_tetris_display_properties.sv
/*
 * concurrent checks on credits, fifo flags and sync outputs
 * bound into renderer, fifo and scan-out
 */
`timescale 1ns/1ps
`default_nettype none

module tb_tetris_display_properties #(
	parameter int FIFO_DEPTH = 16
) (
	input wire clk,
	input wire rst,
	input wire [31:0] credits,
	input wire push,
	input wire full,
	input wire pop,
	input wire empty,
	input wire vga_de,
	input wire vga_hs
);

	// producer never owns more slots than the fifo has
	credits_bounded: assert property (@(posedge clk) disable iff (rst)
		credits <= FIFO_DEPTH) else $error("credit count above fifo depth");

	no_push_when_full: assert property (@(posedge clk) disable iff (rst)
		!(push && full)) else $error("push while fifo full");

	no_pop_when_empty: assert property (@(posedge clk) disable iff (rst)
		!(pop && empty)) else $error("pop while fifo empty");

	// active video and horizontal sync never overlap
	de_outside_hsync: assert property (@(posedge clk) disable iff (rst)
		!(vga_de && !vga_hs)) else $error("vga_de high during vga_hs pulse");

endmodule

// unused inputs tied to values that keep their checks idle
bind pixel_render tb_tetris_display_properties #(.FIFO_DEPTH(FIFO_DEPTH)) u_render_props (
	.clk(clk), .rst(rst), .credits(32'(credits)), .push(1'b0), .full(1'b0),
	.pop(1'b0), .empty(1'b0), .vga_de(1'b0), .vga_hs(1'b1)
);

bind pixel_fifo tb_tetris_display_properties u_fifo_props (
	.clk(clk), .rst(rst), .credits(32'd0), .push(push), .full(full),
	.pop(pop), .empty(empty), .vga_de(1'b0), .vga_hs(1'b1)
);

bind vga_scan_out tb_tetris_display_properties u_scan_props (
	.clk(clk), .rst(rst), .credits(32'd0), .push(1'b0), .full(1'b0),
	.pop(1'b0), .empty(1'b0), .vga_de(vga_de), .vga_hs(vga_hs)
);

`default_nettype wire

//--- rtl/tetris_display_top.sv
/*
 * top level of the piece display
 * piece control, renderer, pixel fifo and scan-out
 */
`timescale 1ns/1ps
`default_nettype none

module tetris_display_top #(
	// default raster is 640x480 at 25 MHz pixel rate
	parameter int H_ACTIVE = 640,
	parameter int H_FRONT = 16,
	parameter int H_SYNC = 96,
	parameter int H_BACK = 48,
	parameter int V_ACTIVE = 480,
	parameter int V_FRONT = 10,
	parameter int V_SYNC = 2,
	parameter int V_BACK = 33,
	// 20 pixel cells, field centred horizontally
	parameter int CELL_SIZE = 20,
	parameter int FIELD_X0 = 220,
	parameter int FIELD_Y0 = 40,
	parameter int FIFO_DEPTH = 16
) (
	input wire clk,
	input wire rst,
	input wire tetris_pkg::keycode_t keycode,
	input wire tetris_pkg::shape_t shape_sel,
	output logic vga_hs,
	output logic vga_vs,
	output logic vga_de,
	output logic [3:0] vga_r,
	output logic [3:0] vga_g,
	output logic [3:0] vga_b
);
	import tetris_pkg::*;

	grid_col_t piece_col;
	grid_row_t piece_row;
	shape_t piece_shape;
	rot_t piece_rot;
	logic frame_done;
	// producer to fifo
	logic push;
	rgb_t push_color;
	// fifo to consumer, credits back to producer
	logic pop;
	rgb_t pop_color;
	logic credit_return;
	rgb_t vga_color;

	piece_control u_piece_control (
		.clk(clk),
		.rst(rst),
		.keycode(keycode),
		.shape_sel(shape_sel),
		.frame_done(frame_done),
		.piece_col(piece_col),
		.piece_row(piece_row),
		.piece_shape(piece_shape),
		.piece_rot(piece_rot)
	);

	pixel_render #(
		.H_ACTIVE(H_ACTIVE),
		.V_ACTIVE(V_ACTIVE),
		.CELL_SIZE(CELL_SIZE),
		.FIELD_X0(FIELD_X0),
		.FIELD_Y0(FIELD_Y0),
		.FIFO_DEPTH(FIFO_DEPTH)
	) u_pixel_render (
		.clk(clk),
		.rst(rst),
		.piece_col(piece_col),
		.piece_row(piece_row),
		.piece_shape(piece_shape),
		.piece_rot(piece_rot),
		.credit_return(credit_return),
		.push(push),
		.push_color(push_color),
		.frame_done(frame_done)
	);

	// status flags not needed here, credits keep the fifo in range
	pixel_fifo #(
		.FIFO_DEPTH(FIFO_DEPTH)
	) u_pixel_fifo (
		.clk(clk),
		.rst(rst),
		.push(push),
		.push_color(push_color),
		.pop(pop),
		.pop_color(pop_color),
		.empty(),
		.full()
	);

	vga_scan_out #(
		.H_ACTIVE(H_ACTIVE),
		.H_FRONT(H_FRONT),
		.H_SYNC(H_SYNC),
		.H_BACK(H_BACK),
		.V_ACTIVE(V_ACTIVE),
		.V_FRONT(V_FRONT),
		.V_SYNC(V_SYNC),
		.V_BACK(V_BACK)
	) u_vga_scan_out (
		.clk(clk),
		.rst(rst),
		.pop_color(pop_color),
		.pop(pop),
		.credit_return(credit_return),
		.vga_hs(vga_hs),
		.vga_vs(vga_vs),
		.vga_de(vga_de),
		.vga_color(vga_color)
	);

	// 4 bit dac channels
	assign vga_r = vga_color[11:8];
	assign vga_g = vga_color[7:4];
	assign vga_b = vga_color[3:0];

endmodule

`default_nettype wire

//--- rtl/vga_scan_out.sv
/*
 * scan timing generator and pixel consumer
 * pops one colour per active pixel, returns credits
 */
`timescale 1ns/1ps
`default_nettype none

module vga_scan_out #(
	parameter int H_ACTIVE = 640,
	parameter int H_FRONT = 16,
	parameter int H_SYNC = 96,
	parameter int H_BACK = 48,
	parameter int V_ACTIVE = 480,
	parameter int V_FRONT = 10,
	parameter int V_SYNC = 2,
	parameter int V_BACK = 33
) (
	input wire clk,
	input wire rst,
	input wire tetris_pkg::rgb_t pop_color,
	output logic pop,
	output logic credit_return,
	output logic vga_hs,
	output logic vga_vs,
	output logic vga_de,
	output tetris_pkg::rgb_t vga_color
);
	import tetris_pkg::*;

	localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
	localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
	localparam int HS_START = H_ACTIVE + H_FRONT;
	localparam int VS_START = V_ACTIVE + V_FRONT;

	// high on every second clock, pixel rate is half of clk
	logic pix_en;
	coord_t h_cnt;
	coord_t v_cnt;
	logic active;
	logic hs_zone;
	logic vs_zone;

	assign active = (int'(h_cnt) < H_ACTIVE) && (int'(v_cnt) < V_ACTIVE);
	assign hs_zone = (int'(h_cnt) >= HS_START) && (int'(h_cnt) < HS_START + H_SYNC);
	assign vs_zone = (int'(v_cnt) >= VS_START) && (int'(v_cnt) < VS_START + V_SYNC);

	// consumer never stalls
	assign pop = pix_en && active;
	// each pop frees one fifo slot
	assign credit_return = pop;

	// ======================================================================
	// counters, start in vertical front porch
	// ======================================================================
	always_ff @(posedge clk) begin
		if (rst) begin
			pix_en <= 1'b0;
			h_cnt <= '0;
			v_cnt <= coord_t'(V_ACTIVE);
		end else begin
			pix_en <= ~pix_en;
			if (pix_en) begin
				if (int'(h_cnt) == H_TOTAL - 1) begin
					h_cnt <= '0;
					if (int'(v_cnt) == V_TOTAL - 1)
						v_cnt <= '0;
					else
						v_cnt <= v_cnt + 1'b1;
				end else begin
					h_cnt <= h_cnt + 1'b1;
				end
			end
		end
	end

	// ======================================================================
	// outputs, one clock behind the counters, held for a pixel
	// ======================================================================
	always_ff @(posedge clk) begin
		if (rst) begin
			vga_hs <= 1'b1;
			vga_vs <= 1'b1;
			vga_de <= 1'b0;
			vga_color <= '0;
		end else if (pix_en) begin
			// active-low sync pulses
			vga_hs <= ~hs_zone;
			vga_vs <= ~vs_zone;
			vga_de <= active;
			// blank outside the active area
			vga_color <= active ? pop_color : '0;
		end
	end

endmodule

`default_nettype wire

//--- rtl/pixel_fifo.sv
/*
 * circular buffer of pixel colours
 */
`timescale 1ns/1ps
`default_nettype none

module pixel_fifo #(
	parameter int FIFO_DEPTH = 16
) (
	input wire clk,
	input wire rst,
	input wire push,
	input wire tetris_pkg::rgb_t push_color,
	input wire pop,
	output tetris_pkg::rgb_t pop_color,
	output logic empty,
	output logic full
);
	import tetris_pkg::*;

	localparam int AW = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	localparam int CW = $clog2(FIFO_DEPTH + 1);

	rgb_t mem [FIFO_DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [CW-1:0] count;
	logic do_push;
	logic do_pop;

	assign empty = (count == '0);
	assign full = (count == CW'(FIFO_DEPTH));
	// head entry, valid while not empty
	assign pop_color = mem[rd_ptr];

	// requests outside the legal range are ignored
	assign do_push = push && !full;
	assign do_pop = pop && !empty;

	always_ff @(posedge clk) begin
		if (do_push)
			mem[wr_ptr] <= push_color;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			// pointers wrap at depth, not only at powers of two
			if (do_push)
				wr_ptr <= (wr_ptr == AW'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == AW'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			if (do_push && !do_pop)
				count <= count + 1'b1;
			else if (do_pop && !do_push)
				count <= count - 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- rtl/pixel_render.sv
/*
 * pixel producer, walks the active area ahead of the raster
 * colour classification and credit counter
 */
`timescale 1ns/1ps
`default_nettype none

module pixel_render #(
	parameter int H_ACTIVE = 640,
	parameter int V_ACTIVE = 480,
	parameter int CELL_SIZE = 20,
	parameter int FIELD_X0 = 220,
	parameter int FIELD_Y0 = 40,
	parameter int FIFO_DEPTH = 16
) (
	input wire clk,
	input wire rst,
	input wire tetris_pkg::grid_col_t piece_col,
	input wire tetris_pkg::grid_row_t piece_row,
	input wire tetris_pkg::shape_t piece_shape,
	input wire tetris_pkg::rot_t piece_rot,
	input wire credit_return,
	output logic push,
	output tetris_pkg::rgb_t push_color,
	output logic frame_done
);
	import tetris_pkg::*;

	localparam int CREDIT_W = $clog2(FIFO_DEPTH + 1);
	// field edges in pixels, exclusive
	localparam int FIELD_X1 = FIELD_X0 + FIELD_COLS * CELL_SIZE;
	localparam int FIELD_Y1 = FIELD_Y0 + FIELD_ROWS * CELL_SIZE;

	render_state_t state;
	coord_t x;
	coord_t y;
	logic [CREDIT_W-1:0] credits;
	logic issue;

	logic [15:0] offs;
	logic in_field;
	logic on_piece;
	int grid_x;
	int grid_y;
	rgb_t pix_color;

	// one pixel per clock while a free fifo slot is owed to us
	assign issue = (state == RS_RUN) && (credits != '0);

	// ======================================================================
	// colour of the pixel at (x, y)
	// ======================================================================
	always_comb begin
		offs = piece_cell_offsets(piece_shape, piece_rot);
		in_field = (int'(x) >= FIELD_X0) && (int'(x) < FIELD_X1) &&
			(int'(y) >= FIELD_Y0) && (int'(y) < FIELD_Y1);
		// cell under the pixel, only meaningful inside the field
		grid_x = (int'(x) - FIELD_X0) / CELL_SIZE;
		grid_y = (int'(y) - FIELD_Y0) / CELL_SIZE;
		on_piece = 1'b0;
		// box column wraps at 16, 15 is one left of the field
		for (int i = 0; i < 4; i++) begin
			if (grid_x == int'(grid_col_t'(piece_col + offs[15-4*i -: 2])) &&
				grid_y == int'(piece_row) + int'(offs[13-4*i -: 2]))
				on_piece = 1'b1;
		end
		if (!in_field)
			pix_color = COLOR_BG;
		else if (on_piece)
			pix_color = SHAPE_COLOR[piece_shape];
		else
			pix_color = COLOR_FIELD;
	end

	// colour register, loaded with each issued pixel
	always_ff @(posedge clk) begin
		if (issue)
			push_color <= pix_color;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= RS_RUN;
			x <= '0;
			y <= '0;
			credits <= CREDIT_W'(FIFO_DEPTH);
			push <= 1'b0;
			frame_done <= 1'b0;
		end else begin
			push <= issue;
			frame_done <= 1'b0;
			// gap lasts one clock while piece_control updates
			if (state == RS_GAP)
				state <= RS_RUN;
			if (issue) begin
				if (int'(x) == H_ACTIVE - 1) begin
					x <= '0;
					if (int'(y) == V_ACTIVE - 1) begin
						y <= '0;
						frame_done <= 1'b1;
						state <= RS_GAP;
					end else begin
						y <= y + 1'b1;
					end
				end else begin
					x <= x + 1'b1;
				end
			end
			// spend on issue, refund on pop
			case ({issue, credit_return})
				2'b10: credits <= credits - 1'b1;
				2'b01: credits <= credits + 1'b1;
				default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- rtl/piece_control.sv
/*
 * falling piece state, moved by key presses
 * moves and shape changes applied at frame boundaries
 */
`timescale 1ns/1ps
`default_nettype none

module piece_control (
	input wire clk,
	input wire rst,
	input wire tetris_pkg::keycode_t keycode,
	input wire tetris_pkg::shape_t shape_sel,
	input wire frame_done,
	output tetris_pkg::grid_col_t piece_col,
	output tetris_pkg::grid_row_t piece_row,
	output tetris_pkg::shape_t piece_shape,
	output tetris_pkg::rot_t piece_rot
);
	import tetris_pkg::*;

	localparam grid_col_t START_COL = 4'd3;

	keycode_t key_prev;
	move_cmd_t key_cmd;
	move_cmd_t pending_cmd;
	logic press;

	// candidate position after the pending move
	int cand_col;
	int cand_row;
	rot_t cand_rot;
	logic move_ok;
	// position kept after the move check
	int base_col;
	int base_row;
	rot_t base_rot;
	shape_t new_shape;
	logic shape_ok;

	// true when all four cells land inside the field
	function automatic logic piece_fits(input shape_t s, input rot_t r,
		input int col, input int row);
		logic [15:0] offs;
		int c;
		int rw;
		offs = piece_cell_offsets(s, r);
		piece_fits = 1'b1;
		for (int i = 0; i < 4; i++) begin
			// box column wraps at 16, 15 is one left of the field
			c = int'(grid_col_t'(col + int'(offs[15-4*i -: 2])));
			rw = row + int'(offs[13-4*i -: 2]);
			if (c >= FIELD_COLS || rw < 0 || rw >= FIELD_ROWS)
				piece_fits = 1'b0;
		end
	endfunction

	// keycode to command
	always_comb begin
		case (keycode)
			KEY_LEFT: key_cmd = CMD_LEFT;
			KEY_RIGHT: key_cmd = CMD_RIGHT;
			KEY_DOWN: key_cmd = CMD_DOWN;
			KEY_ROTATE: key_cmd = CMD_ROTATE;
			default: key_cmd = CMD_NONE;
		endcase
	end

	// new press only after the key was released
	assign press = (key_prev == 8'h00) && (key_cmd != CMD_NONE);

	always_comb begin
		cand_col = int'(piece_col);
		cand_row = int'(piece_row);
		cand_rot = piece_rot;
		case (pending_cmd)
			CMD_LEFT: cand_col = int'(piece_col) - 1;
			CMD_RIGHT: cand_col = int'(piece_col) + 1;
			CMD_DOWN: cand_row = int'(piece_row) + 1;
			CMD_ROTATE: cand_rot = piece_rot + 2'd1;
			default: ;
		endcase
		move_ok = piece_fits(piece_shape, cand_rot, cand_col, cand_row);
		// refused move leaves the piece where it is
		base_col = move_ok ? cand_col : int'(piece_col);
		base_row = move_ok ? cand_row : int'(piece_row);
		base_rot = move_ok ? cand_rot : piece_rot;
		// 0 and 7 on shape_sel mean no change
		new_shape = (shape_sel != 3'd0 && shape_sel != 3'd7) ? shape_sel : piece_shape;
		shape_ok = piece_fits(new_shape, base_rot, base_col, base_row);
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			key_prev <= 8'h00;
			pending_cmd <= CMD_NONE;
			piece_col <= START_COL;
			piece_row <= '0;
			piece_rot <= '0;
			piece_shape <= (shape_sel == 3'd7) ? 3'd0 : shape_sel;
		end else begin
			key_prev <= keycode;
			// latest press wins, otherwise cleared once consumed
			if (press)
				pending_cmd <= key_cmd;
			else if (frame_done)
				pending_cmd <= CMD_NONE;
			if (frame_done) begin
				piece_col <= grid_col_t'(base_col);
				piece_row <= grid_row_t'(base_row);
				piece_rot <= base_rot;
				if (shape_ok)
					piece_shape <= new_shape;
			end
		end
	end

endmodule

`default_nettype wire

//--- rtl/tetris_pkg.sv
/*
 * shared widths, move commands and render states
 * key codes, field size and colours
 * tetromino cell offset table
 */
`default_nettype none

package tetris_pkg;

	// ======================================================================
	// types
	// ======================================================================
	typedef logic [9:0] coord_t;
	typedef logic [3:0] grid_col_t;
	typedef logic [4:0] grid_row_t;
	// 0 I, 1 O, 2 T, 3 S, 4 Z, 5 J, 6 L, 7 invalid
	typedef logic [2:0] shape_t;
	typedef logic [1:0] rot_t;
	// {red, green, blue}, 4 bits each
	typedef logic [11:0] rgb_t;
	typedef logic [7:0] keycode_t;

	typedef enum logic [2:0] {CMD_NONE, CMD_LEFT, CMD_RIGHT, CMD_DOWN, CMD_ROTATE} move_cmd_t;
	typedef enum logic {RS_RUN, RS_GAP} render_state_t;

	// keyboard usage codes
	localparam keycode_t KEY_LEFT = 8'h04;
	localparam keycode_t KEY_RIGHT = 8'h07;
	localparam keycode_t KEY_DOWN = 8'h16;
	localparam keycode_t KEY_ROTATE = 8'h1A;

	// playfield in cells
	localparam int FIELD_COLS = 10;
	localparam int FIELD_ROWS = 20;

	localparam rgb_t COLOR_BG = 12'h000;
	localparam rgb_t COLOR_FIELD = 12'h222;
	// indexed by shape_t, last entry never drawn
	localparam rgb_t SHAPE_COLOR [8] = '{12'h0ff, 12'hff0, 12'ha0f, 12'h0f0,
		12'hf00, 12'h00f, 12'hf80, 12'hfff};

	// ======================================================================
	// shape table
	// ======================================================================
	// four cells inside a 4x4 box, cell 0 in the top nibble
	// each nibble is {col[1:0], row[1:0]}
	function automatic logic [15:0] piece_cell_offsets(input shape_t shape, input rot_t rot);
		logic [15:0] offs;
		casez ({shape, rot})
			// I, horizontal and vertical only
			5'b000_?0: offs = 16'b0001_0101_1001_1101;
			5'b000_?1: offs = 16'b0100_0101_0110_0111;
			// O looks the same in every rotation
			5'b001_??: offs = 16'b0100_1000_0101_1001;
			// T
			5'b010_00: offs = 16'b0100_0001_0101_1001;
			5'b010_01: offs = 16'b0100_0101_1001_0110;
			5'b010_10: offs = 16'b0001_0101_1001_0110;
			5'b010_11: offs = 16'b0100_0001_0101_0110;
			// S and Z have two distinct poses
			5'b011_?0: offs = 16'b0100_1000_0001_0101;
			5'b011_?1: offs = 16'b0100_0101_1001_1010;
			5'b100_?0: offs = 16'b0000_0100_0101_1001;
			5'b100_?1: offs = 16'b1000_0101_1001_0110;
			// J
			5'b101_00: offs = 16'b0000_0001_0101_1001;
			5'b101_01: offs = 16'b0100_1000_0101_0110;
			5'b101_10: offs = 16'b0001_0101_1001_1010;
			5'b101_11: offs = 16'b0100_0101_0010_0110;
			// L
			5'b110_00: offs = 16'b1000_0001_0101_1001;
			5'b110_01: offs = 16'b0100_0101_0110_1010;
			5'b110_10: offs = 16'b0001_0101_1001_0010;
			5'b110_11: offs = 16'b0000_0100_0101_0110;
			default: offs = 16'b0000_0000_0000_0000;
		endcase
		return offs;
	endfunction

endpackage

`default_nettype wire
